// ==== design/helios_config.svh ====
`ifndef HELIOS_CONFIG_SVH
`define HELIOS_CONFIG_SVH

// architectural register count
`define ARF_NUM 32

// rename entries, one per reorder slot
`define RRF_NUM 8
`define RRF_SEL 3

// identical ALU reservation slices
`define ALU_SLICES 4

`define DATA_LEN 32

`endif

// ==== design/helios_pkg.sv ====
`default_nettype none

`include "helios_config.svh"

package helios_pkg;

    typedef logic [`RRF_SEL-1:0] rrf_tag_t;
    typedef logic [`RRF_SEL:0] rrf_cnt_t;
    typedef logic [4:0] reg_sel_t;
    typedef logic [$clog2(`ALU_SLICES)-1:0] slice_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_e;

    // OP-IMM major opcode, everything else is taken as OP
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef struct packed {
        logic [6:0] funct7;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        reg_sel_t   rd;
        logic [6:0] opcode;
    } r_insn_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_sel_t    rs1;
        logic [2:0]  funct3;
        reg_sel_t    rd;
        logic [6:0]  opcode;
    } i_insn_t;

    // low fields shared, upper bits are funct7/rs2 or imm12
    typedef union packed {
        r_insn_t r;
        i_insn_t i;
    } insn_u;

    typedef struct packed {
        logic [`DATA_LEN-1:0] value;
        logic                 ready;
        rrf_tag_t             tag;
    } operand_t;

endpackage

`default_nettype wire

// ==== design/issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

interface issue_if
    import helios_pkg::*;
();

    logic                 valid;
    alu_op_e              op;
    operand_t             src1;
    operand_t             src2;
    rrf_tag_t             tag;
    logic                 busy;

    // completion side, gathered onto the result bus at the top
    logic                 done;
    logic [`DATA_LEN-1:0] result;
    rrf_tag_t             res_tag;

    modport dispatcher (output valid, op, src1, src2, tag, input busy);

    modport station (
        input  valid, op, src1, src2, tag,
        output busy, done, result, res_tag
    );

endinterface

`default_nettype wire

// ==== design/cdb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

interface cdb_if
    import helios_pkg::*;
();

    logic                                  cdb_valid;
    rrf_tag_t                              cdb_tag;
    logic [`DATA_LEN-1:0]                  cdb_data;
    logic [`ALU_SLICES-1:0]                grant;

    // one lane per slice
    logic [`ALU_SLICES-1:0]                done;
    logic [`ALU_SLICES-1:0][`DATA_LEN-1:0] result;
    rrf_tag_t [`ALU_SLICES-1:0]            res_tag;

    modport arbiter (output cdb_valid, cdb_tag, cdb_data, grant, input done, result, res_tag);
    modport station (input cdb_valid, cdb_tag, cdb_data, grant);
    modport snoop (input cdb_valid, cdb_tag, cdb_data);

endinterface

`default_nettype wire

// ==== design/rob_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

interface rob_if
    import helios_pkg::*;
();

    logic                 alloc;
    reg_sel_t             alloc_rd;
    logic                 free_ok;
    rrf_tag_t             alloc_tag;

    rrf_tag_t             look_tag1;
    rrf_tag_t             look_tag2;
    logic                 look_done1;
    logic                 look_done2;
    logic [`DATA_LEN-1:0] look_data1;
    logic [`DATA_LEN-1:0] look_data2;

    logic                 retire;
    rrf_tag_t             retire_tag;
    reg_sel_t             retire_rd;
    logic [`DATA_LEN-1:0] retire_data;

    modport rename (
        output alloc, alloc_rd, look_tag1, look_tag2,
        input  free_ok, alloc_tag, look_done1, look_done2, look_data1, look_data2,
        input  retire, retire_tag, retire_rd, retire_data
    );

    modport reorder (
        input  alloc, alloc_rd, look_tag1, look_tag2,
        output free_ok, alloc_tag, look_done1, look_done2, look_data1, look_data2,
        output retire, retire_tag, retire_rd, retire_data
    );

endinterface

`default_nettype wire

// ==== design/rename_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

module rename_dispatch
    import helios_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rst_n_i,
    input  wire logic   insn_req_i,
    input  wire insn_u  insn_i,
    output logic        insn_ack_o,
    issue_if.dispatcher issue [`ALU_SLICES],
    cdb_if.snoop        cdb,
    rob_if.rename       rob
);

    logic [`DATA_LEN-1:0]   arf_q [`ARF_NUM];
    logic [`ARF_NUM-1:0]    map_busy_q;
    rrf_tag_t               map_tag_q [`ARF_NUM];

    logic                   is_imm;
    alu_op_e                op_d;
    reg_sel_t               rs1;
    reg_sel_t               rs2;
    reg_sel_t               rd;
    logic [`DATA_LEN-1:0]   imm_ext;
    logic                   fwd_ok1;
    logic                   fwd_ok2;
    logic [`DATA_LEN-1:0]   fwd_val1;
    logic [`DATA_LEN-1:0]   fwd_val2;
    operand_t               src1_d;
    operand_t               src2_d;
    logic [`ALU_SLICES-1:0] slice_busy;
    logic [`ALU_SLICES-1:0] slice_free;
    logic [`ALU_SLICES-1:0] slice_sel;
    logic                   accept;

    function automatic operand_t fetch_src(
        input reg_sel_t             rs,
        input logic [`DATA_LEN-1:0] arf_val,
        input logic                 busy,
        input rrf_tag_t             tag,
        input logic                 fwd_ok,
        input logic [`DATA_LEN-1:0] fwd_val
    );
        operand_t src;
        src.value = '0;
        src.ready = 1'b1;
        src.tag   = tag;
        if (rs == '0) begin
            src.value = '0;
        end else if (!busy) begin
            src.value = arf_val;
        end else if (fwd_ok) begin
            src.value = fwd_val;
        end else begin
            src.ready = 1'b0;
        end
        return src;
    endfunction

    assign rs1     = insn_i.r.rs1;
    assign rs2     = insn_i.r.rs2;
    assign rd      = insn_i.r.rd;
    assign is_imm  = (insn_i.i.opcode == OPC_OP_IMM);
    assign imm_ext = {{(`DATA_LEN-12){insn_i.i.imm12[11]}}, insn_i.i.imm12};

    always_comb begin
        case (insn_i.r.funct3)
            3'b000:  op_d = (!is_imm && insn_i.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  op_d = ALU_SLL;
            3'b010:  op_d = ALU_SLT;
            3'b100:  op_d = ALU_XOR;
            3'b101:  op_d = ALU_SRL;
            3'b110:  op_d = ALU_OR;
            3'b111:  op_d = ALU_AND;
            default: op_d = ALU_ADD;
        endcase
    end

    // renamed sources: done entry first, then same-cycle broadcast
    assign rob.look_tag1 = map_tag_q[rs1];
    assign rob.look_tag2 = map_tag_q[rs2];
    assign fwd_ok1  = rob.look_done1 || (cdb.cdb_valid && cdb.cdb_tag == rob.look_tag1);
    assign fwd_ok2  = rob.look_done2 || (cdb.cdb_valid && cdb.cdb_tag == rob.look_tag2);
    assign fwd_val1 = rob.look_done1 ? rob.look_data1 : cdb.cdb_data;
    assign fwd_val2 = rob.look_done2 ? rob.look_data2 : cdb.cdb_data;

    always_comb begin
        src1_d = fetch_src(rs1, arf_q[rs1], map_busy_q[rs1], rob.look_tag1, fwd_ok1, fwd_val1);
        if (is_imm) begin
            src2_d.value = imm_ext;
            src2_d.ready = 1'b1;
            src2_d.tag   = '0;
        end else begin
            src2_d = fetch_src(rs2, arf_q[rs2], map_busy_q[rs2], rob.look_tag2, fwd_ok2,
                               fwd_val2);
        end
    end

    // lowest free slice
    assign slice_free = ~slice_busy;
    assign slice_sel  = slice_free & (-slice_free);
    assign accept     = insn_req_i && !insn_ack_o && rob.free_ok && (|slice_free);

    assign rob.alloc    = accept;
    assign rob.alloc_rd = rd;

    for (genvar g = 0; g < `ALU_SLICES; g++) begin : g_issue
        assign slice_busy[g]  = issue[g].busy;
        assign issue[g].valid = accept && slice_sel[g];
        assign issue[g].op    = op_d;
        assign issue[g].src1  = src1_d;
        assign issue[g].src2  = src2_d;
        assign issue[g].tag   = rob.alloc_tag;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            insn_ack_o <= 1'b0;
            map_busy_q <= '0;
            for (int r = 0; r < `ARF_NUM; r++) begin
                arf_q[r] <= '0;
            end
        end else begin
            if (accept) begin
                insn_ack_o <= 1'b1;
            end else if (!insn_req_i) begin
                insn_ack_o <= 1'b0;
            end
            if (rob.retire && rob.retire_rd != '0) begin
                arf_q[rob.retire_rd] <= rob.retire_data;
                // a newer writer keeps the map entry
                if (map_tag_q[rob.retire_rd] == rob.retire_tag) begin
                    map_busy_q[rob.retire_rd] <= 1'b0;
                end
            end
            if (accept && rd != '0) begin
                map_busy_q[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && rd != '0) begin
            map_tag_q[rd] <= rob.alloc_tag;
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_station.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

module alu_station
    import helios_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    issue_if.station        issue,
    cdb_if.station          cdb,
    input  wire slice_idx_t slice_idx_i
);

    logic                 busy_q;
    alu_op_e              op_q;
    operand_t             src1_q;
    operand_t             src2_q;
    rrf_tag_t             tag_q;
    logic [`DATA_LEN-1:0] res;

    function automatic operand_t wake(
        input operand_t             src,
        input logic                 bus_valid,
        input rrf_tag_t             bus_tag,
        input logic [`DATA_LEN-1:0] bus_data
    );
        operand_t upd;
        upd = src;
        if (!src.ready && bus_valid && bus_tag == src.tag) begin
            upd.value = bus_data;
            upd.ready = 1'b1;
        end
        return upd;
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (issue.valid) begin
            busy_q <= 1'b1;
        end else if (cdb.grant[slice_idx_i]) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue.valid) begin
            op_q   <= issue.op;
            src1_q <= issue.src1;
            src2_q <= issue.src2;
            tag_q  <= issue.tag;
        end else if (busy_q) begin
            src1_q <= wake(src1_q, cdb.cdb_valid, cdb.cdb_tag, cdb.cdb_data);
            src2_q <= wake(src2_q, cdb.cdb_valid, cdb.cdb_tag, cdb.cdb_data);
        end
    end

    always_comb begin
        case (op_q)
            ALU_ADD: res = src1_q.value + src2_q.value;
            ALU_SUB: res = src1_q.value - src2_q.value;
            ALU_AND: res = src1_q.value & src2_q.value;
            ALU_OR:  res = src1_q.value | src2_q.value;
            ALU_XOR: res = src1_q.value ^ src2_q.value;
            ALU_SLL: res = src1_q.value << src2_q.value[4:0];
            ALU_SRL: res = src1_q.value >> src2_q.value[4:0];
            ALU_SLT: res = {{(`DATA_LEN-1){1'b0}}, $signed(src1_q.value) < $signed(src2_q.value)};
            default: res = '0;
        endcase
    end

    // done holds until the arbiter picks this slice
    assign issue.busy    = busy_q;
    assign issue.done    = busy_q && src1_q.ready && src2_q.ready;
    assign issue.result  = res;
    assign issue.res_tag = tag_q;

endmodule

`default_nettype wire

// ==== design/commit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

module commit_unit
    import helios_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    cdb_if.arbiter               cdb,
    rob_if.reorder               rob,
    output logic                 commit_valid_o,
    output reg_sel_t             commit_rd_o,
    output logic [`DATA_LEN-1:0] commit_data_o
);

    reg_sel_t             rd_q   [`RRF_NUM];
    logic [`DATA_LEN-1:0] data_q [`RRF_NUM];
    logic [`RRF_NUM-1:0]  done_q;
    rrf_tag_t             head_q;
    rrf_tag_t             tail_q;
    rrf_cnt_t             count_q;
    slice_idx_t           win_idx;

    // fixed priority, lowest slice wins
    always_comb begin
        win_idx = '0;
        for (int s = `ALU_SLICES - 1; s >= 0; s--) begin
            if (cdb.done[s]) begin
                win_idx = slice_idx_t'(s);
            end
        end
    end

    assign cdb.grant     = cdb.done & (-cdb.done);
    assign cdb.cdb_valid = |cdb.done;
    assign cdb.cdb_tag   = cdb.res_tag[win_idx];
    assign cdb.cdb_data  = cdb.result[win_idx];

    assign rob.free_ok   = (count_q != rrf_cnt_t'(`RRF_NUM));
    assign rob.alloc_tag = tail_q;

    assign rob.look_done1 = done_q[rob.look_tag1];
    assign rob.look_done2 = done_q[rob.look_tag2];
    assign rob.look_data1 = data_q[rob.look_tag1];
    assign rob.look_data2 = data_q[rob.look_tag2];

    // head leaves once its result is in
    assign rob.retire      = (count_q != '0) && done_q[head_q];
    assign rob.retire_tag  = head_q;
    assign rob.retire_rd   = rd_q[head_q];
    assign rob.retire_data = data_q[head_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            done_q         <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            if (rob.alloc) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb.cdb_valid) begin
                done_q[cdb.cdb_tag] <= 1'b1;
            end
            if (rob.retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({rob.alloc, rob.retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            commit_valid_o <= rob.retire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rob.alloc) begin
            rd_q[tail_q] <= rob.alloc_rd;
        end
        if (cdb.cdb_valid) begin
            data_q[cdb.cdb_tag] <= cdb.cdb_data;
        end
        if (rob.retire) begin
            commit_rd_o   <= rob.retire_rd;
            commit_data_o <= rob.retire_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/helios_ooo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

module helios_ooo_top
    import helios_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            insn_req_i,
    input  wire logic [31:0]     insn_i,
    output logic                 insn_ack_o,
    output logic                 commit_valid_o,
    output reg_sel_t             commit_rd_o,
    output logic [`DATA_LEN-1:0] commit_data_o
);

    issue_if issue_bus [`ALU_SLICES] ();
    cdb_if   cdb_bus ();
    rob_if   rob_bus ();

    rename_dispatch i_rename_dispatch (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .insn_req_i (insn_req_i),
        .insn_i     (insn_i),
        .insn_ack_o (insn_ack_o),
        .issue      (issue_bus),
        .cdb        (cdb_bus),
        .rob        (rob_bus)
    );

    for (genvar g = 0; g < `ALU_SLICES; g++) begin : g_slice
        alu_station i_alu_station (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .issue       (issue_bus[g]),
            .cdb         (cdb_bus),
            .slice_idx_i (slice_idx_t'(g))
        );

        // slice lane onto the result bus
        assign cdb_bus.done[g]    = issue_bus[g].done;
        assign cdb_bus.result[g]  = issue_bus[g].result;
        assign cdb_bus.res_tag[g] = issue_bus[g].res_tag;
    end

    commit_unit i_commit_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .cdb            (cdb_bus),
        .rob            (rob_bus),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN    = 28;
// requests from here on go out back to back
localparam int BURST_START = 17;

logic [31:0] program_rom [PROG_LEN];

task automatic load_program();
    // operands, then every op in R and I form
    program_rom[0]  = enc_i(5, 0, F3_ADD, 1);
    program_rom[1]  = enc_i(-3, 0, F3_ADD, 2);
    program_rom[2]  = enc_r(0, 2, 1, F3_ADD, 3);
    program_rom[3]  = enc_r(32, 2, 1, F3_ADD, 4);
    program_rom[4]  = enc_r(0, 2, 1, F3_AND, 5);
    program_rom[5]  = enc_r(0, 2, 1, F3_OR, 6);
    program_rom[6]  = enc_r(0, 2, 1, F3_XOR, 7);
    program_rom[7]  = enc_i(33, 0, F3_ADD, 8);
    // shift amount 33, only the low 5 bits count
    program_rom[8]  = enc_r(0, 8, 1, F3_SLL, 9);
    program_rom[9]  = enc_r(0, 8, 2, F3_SRL, 10);
    program_rom[10] = enc_r(0, 1, 2, F3_SLT, 11);
    program_rom[11] = enc_i(-1, 1, F3_SLT, 12);
    program_rom[12] = enc_i('h7ff, 1, F3_XOR, 13);
    program_rom[13] = enc_i('h0f0, 2, F3_OR, 14);
    program_rom[14] = enc_i('h8f0, 2, F3_AND, 15);
    program_rom[15] = enc_i(31, 1, F3_SLL, 16);
    program_rom[16] = enc_i(28, 2, F3_SRL, 17);
    // dependent chain on x20, rewritten while in flight
    program_rom[17] = enc_i(1, 1, F3_ADD, 20);
    program_rom[18] = enc_r(0, 20, 20, F3_ADD, 20);
    program_rom[19] = enc_r(32, 1, 20, F3_ADD, 20);
    program_rom[20] = enc_i(2, 20, F3_SLL, 20);
    program_rom[21] = enc_r(0, 20, 20, F3_ADD, 0);
    program_rom[22] = enc_r(0, 20, 0, F3_ADD, 21);
    program_rom[23] = enc_i(-7, 20, F3_ADD, 20);
    program_rom[24] = enc_r(0, 21, 20, F3_XOR, 22);
    // independent work behind the slow one
    program_rom[25] = enc_i(1, 0, F3_ADD, 23);
    program_rom[26] = enc_i(2, 0, F3_ADD, 24);
    program_rom[27] = enc_r(0, 3, 22, F3_OR, 25);
endtask

`endif

// ==== dv/tb_helios_ooo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "helios_config.svh"

module tb_helios_ooo
    import helios_pkg::*;
();

    localparam int F3_ADD = 0;
    localparam int F3_SLL = 1;
    localparam int F3_SLT = 2;
    localparam int F3_XOR = 4;
    localparam int F3_SRL = 5;
    localparam int F3_OR  = 6;
    localparam int F3_AND = 7;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 insn_req_i;
    logic [31:0]          insn_i;
    logic                 insn_ack_o;
    logic                 commit_valid_o;
    reg_sel_t             commit_rd_o;
    logic [`DATA_LEN-1:0] commit_data_o;

    logic [`DATA_LEN-1:0] arf_model [`ARF_NUM];
    reg_sel_t             exp_rd_q [$];
    logic [`DATA_LEN-1:0] exp_data_q [$];
    int                   commit_count;

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    `include "tb_program.svh"

    localparam int TIMEOUT_CYCLES = PROG_LEN * 40;

    helios_ooo_top i_helios_ooo_top (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .insn_req_i     (insn_req_i),
        .insn_i         (insn_i),
        .insn_ack_o     (insn_ack_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    task automatic check_rd(input reg_sel_t got, input reg_sel_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got x%0d, expected x%0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_data(input logic [`DATA_LEN-1:0] got,
                              input logic [`DATA_LEN-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // architectural result of one instruction in program order
    task automatic model_step(input logic [31:0] word);
        logic                 is_imm;
        logic [`DATA_LEN-1:0] a;
        logic [`DATA_LEN-1:0] b;
        logic [`DATA_LEN-1:0] r;
        is_imm = (word[6:0] == 7'b0010011);
        a = arf_model[word[19:15]];
        b = is_imm ? {{(`DATA_LEN-12){word[31]}}, word[31:20]} : arf_model[word[24:20]];
        case (word[14:12])
            3'b000:  r = (!is_imm && word[30]) ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        if (word[11:7] != 5'd0) begin
            arf_model[word[11:7]] = r;
        end
        exp_rd_q.push_back(word[11:7]);
        exp_data_q.push_back(r);
    endtask

    // four-phase req/ack
    task automatic send_insn(input logic [31:0] word);
        @(posedge clk_i);
        insn_i     <= word;
        insn_req_i <= 1'b1;
        do @(posedge clk_i); while (!insn_ack_o);
        insn_req_i <= 1'b0;
        do @(posedge clk_i); while (insn_ack_o);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat (TIMEOUT_CYCLES + 3) @(posedge clk_i);
        abort_run($sformatf("timeout: only %0d of %0d instructions committed",
                            commit_count, PROG_LEN));
    end

    always @(posedge clk_i) begin
        if (rst_n_i && commit_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                abort_run("a commit came out with no instruction outstanding");
            end else begin
                check_rd(commit_rd_o, exp_rd_q.pop_front(), "commit rd");
                check_data(commit_data_o, exp_data_q.pop_front(), "commit data");
                commit_count++;
            end
        end
    end

    initial begin
        rst_n_i      = 1'b0;
        insn_req_i   = 1'b0;
        insn_i       = '0;
        commit_count = 0;
        for (int r = 0; r < `ARF_NUM; r++) begin
            arf_model[r] = '0;
        end
        void'($urandom(32'h159d_59b1));
        load_program();
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (int n = 0; n < PROG_LEN; n++) begin
            if (n < BURST_START) begin
                repeat ($urandom_range(3, 0)) @(posedge clk_i);
            end
            model_step(program_rom[n]);
            send_insn(program_rom[n]);
        end

        wait (commit_count == PROG_LEN);
        // extra commits would show up here
        repeat (20) @(posedge clk_i);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== helios_ooo.f ====
+incdir+design
+incdir+dv
design/helios_pkg.sv
design/issue_if.sv
design/cdb_if.sv
design/rob_if.sv
design/rename_dispatch.sv
design/alu_station.sv
design/commit_unit.sv
design/helios_ooo_top.sv
dv/tb_helios_ooo.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_helios_ooo -f helios_ooo.f -o tb_helios_ooo &&
./obj_dir/tb_helios_ooo | grep -x "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
